// File: adc_capture_pkg.sv
`default_nettype none

package adc_capture_pkg;

    localparam int SAMPLE_W         = 12;   // one adc sample
    localparam int SAMPLES_PER_WORD = 3;
    localparam int WORD_W           = SAMPLE_W * SAMPLES_PER_WORD;
    localparam int BYTE_W           = 8;    // readout byte
    localparam int COUNT_W          = 16;   // sample counters, presample and max settings
    localparam int DS_W             = 13;   // downsample setting

    typedef logic [SAMPLE_W-1:0] sample_t;
    typedef logic [WORD_W-1:0]   word_t;    // oldest sample in the top bits

    // capture sequence as seen by controller and packer
    typedef enum logic [2:0] {
        idle,
        presamp_filling,
        presamp_full,
        triggered,
        done
    } capture_state_t;

endpackage

`default_nettype wire

// File: sample_fifo.sv
`default_nettype none

module sample_fifo #(
    parameter int  DEPTH     = 64,
    parameter type payload_t = logic [7:0]
) (
    input  wire           adc_sampleclk,
    input  wire           reset,
    input  wire           clear_i,
    input  wire payload_t din_i,
    input  wire           wr_i,
    input  wire           rd_i,
    output payload_t      dout_o,
    output logic          full_o,
    output logic          empty_o,
    output logic          overflow_o,
    output logic          underflow_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] fill;     // entries held
    logic             do_wr;
    logic             do_rd;

    // wrap explicitly so a non power of two depth also works
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1))
            ptr_inc = '0;
        else
            ptr_inc = ptr + 1'b1;
    endfunction

    assign full_o  = (fill == CNT_W'(DEPTH));
    assign empty_o = (fill == '0);
    assign do_wr   = wr_i & ~full_o;     // blocked writes only raise overflow
    assign do_rd   = rd_i & ~empty_o;
    assign dout_o  = mem[rd_ptr];        // show-ahead head entry

    always_ff @(posedge adc_sampleclk) begin
        if (do_wr)
            mem[wr_ptr] <= din_i;
    end

    always_ff @(posedge adc_sampleclk) begin
        if (reset || clear_i) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            fill        <= '0;
            overflow_o  <= 1'b0;
            underflow_o <= 1'b0;
        end else begin
            overflow_o  <= wr_i & full_o;   // one cycle per bad access
            underflow_o <= rd_i & empty_o;
            if (do_wr)
                wr_ptr <= ptr_inc(wr_ptr);
            if (do_rd)
                rd_ptr <= ptr_inc(rd_ptr);
            if (do_wr && !do_rd)
                fill <= fill + 1'b1;
            else if (do_rd && !do_wr)
                fill <= fill - 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: capture_ctrl.sv
`default_nettype none

module capture_ctrl (
    input  wire                                adc_sampleclk,
    input  wire                                reset,
    input  wire                                arm_i,
    input  wire                                adc_capture_go_i,
    input  wire [adc_capture_pkg::COUNT_W-1:0] presample_i,
    input  wire [adc_capture_pkg::COUNT_W-1:0] max_samples_i,
    input  wire [adc_capture_pkg::DS_W-1:0]    downsample_i,
    input  wire                                sample_empty_i,
    input  wire                                packer_idle_i,
    output logic                               sample_wr_o,
    output logic                               drain_rd_o,
    output logic                               arm_clear_o,
    output adc_capture_pkg::capture_state_t    state_o,
    output logic                               capture_stop_o
);

    logic                                arm_r;
    logic                                arm_r2;
    logic                                armed;       // no presamples, waiting in idle
    logic [adc_capture_pkg::DS_W-1:0]    ds_ctr;
    logic                                ds_keep;
    logic                                capturing;
    logic [adc_capture_pkg::COUNT_W-1:0] sample_cnt;  // samples held for this capture
    logic [adc_capture_pkg::COUNT_W-1:0] sample_cnt_nxt;

    // arm edge seen two flops late, gives the clear pulse
    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            arm_r       <= 1'b0;
            arm_r2      <= 1'b0;
            arm_clear_o <= 1'b0;
        end else begin
            arm_r       <= arm_i;
            arm_r2      <= arm_r;
            arm_clear_o <= arm_r & ~arm_r2;
        end
    end

    // keep one sample, then skip downsample_i
    assign ds_keep = (ds_ctr == downsample_i);

    always_ff @(posedge adc_sampleclk) begin
        if (reset || arm_clear_o)
            ds_ctr <= '0;
        else if (ds_keep)
            ds_ctr <= '0;
        else
            ds_ctr <= ds_ctr + 1'b1;
    end

    assign capturing = (state_o == adc_capture_pkg::presamp_filling) ||
                       (state_o == adc_capture_pkg::presamp_full) ||
                       (state_o == adc_capture_pkg::triggered);

    assign sample_wr_o = capturing & ds_keep;

    // window full: drop the oldest on each new one,
    // except on the trigger edge where the window grows by that sample
    assign drain_rd_o = sample_wr_o & (state_o == adc_capture_pkg::presamp_full) &
                        ~adc_capture_go_i;

    assign sample_cnt_nxt = sample_cnt + 1'b1;

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            state_o        <= adc_capture_pkg::idle;
            armed          <= 1'b0;
            sample_cnt     <= '0;
            capture_stop_o <= 1'b0;
        end else if (arm_clear_o) begin
            // restart from scratch, whatever was running
            sample_cnt     <= '0;
            capture_stop_o <= 1'b0;
            if (presample_i == '0) begin
                armed   <= 1'b1;
                state_o <= adc_capture_pkg::idle;
            end else begin
                armed   <= 1'b0;
                state_o <= adc_capture_pkg::presamp_filling;
            end
        end else begin
            if (sample_wr_o && !drain_rd_o)
                sample_cnt <= sample_cnt_nxt;   // presamples count toward the total

            case (state_o)
                adc_capture_pkg::idle: begin
                    if (armed && adc_capture_go_i) begin
                        armed   <= 1'b0;
                        state_o <= adc_capture_pkg::triggered;
                    end
                end
                adc_capture_pkg::presamp_filling: begin
                    if (adc_capture_go_i)
                        state_o <= adc_capture_pkg::triggered;  // early trigger, short window
                    else if (sample_wr_o && (sample_cnt_nxt == presample_i))
                        state_o <= adc_capture_pkg::presamp_full;
                end
                adc_capture_pkg::presamp_full: begin
                    if (adc_capture_go_i)
                        state_o <= adc_capture_pkg::triggered;
                end
                adc_capture_pkg::triggered: begin
                    if (sample_wr_o && (sample_cnt_nxt == max_samples_i)) begin
                        capture_stop_o <= 1'b1;     // held until next arm
                        state_o        <= adc_capture_pkg::done;
                    end
                end
                adc_capture_pkg::done: begin
                    // wait for the packer to flush the last word
                    if (sample_empty_i && packer_idle_i)
                        state_o <= adc_capture_pkg::idle;
                end
                default: state_o <= adc_capture_pkg::idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: sample_packer.sv
`default_nettype none

module sample_packer (
    input  wire                             adc_sampleclk,
    input  wire                             reset,
    input  wire                             clear_i,
    input  wire adc_capture_pkg::capture_state_t state_i,
    input  wire adc_capture_pkg::sample_t   sample_i,
    input  wire                             sample_empty_i,
    input  wire                             word_full_i,
    output logic                            sample_rd_o,
    output adc_capture_pkg::word_t          word_o,
    output logic                            word_wr_o,
    output logic                            idle_o
);

    localparam int LOW_W = adc_capture_pkg::WORD_W - adc_capture_pkg::SAMPLE_W;

    logic [1:0] pack_cnt;   // samples already in the partial word
    logic       draining;

    assign draining = (state_i == adc_capture_pkg::triggered) ||
                      (state_i == adc_capture_pkg::done);

    // a full word buffer simply stalls the drain
    assign sample_rd_o = draining & ~sample_empty_i & ~word_full_i;

    assign idle_o = (pack_cnt == 2'd0) & ~word_wr_o;

    // shift in at the bottom, oldest ends up in 35:24
    always_ff @(posedge adc_sampleclk) begin
        if (sample_rd_o)
            word_o <= {word_o[LOW_W-1:0], sample_i};
    end

    always_ff @(posedge adc_sampleclk) begin
        if (reset || clear_i) begin
            pack_cnt  <= 2'd0;
            word_wr_o <= 1'b0;
        end else begin
            word_wr_o <= 1'b0;
            if (sample_rd_o) begin
                if (pack_cnt == 2'(adc_capture_pkg::SAMPLES_PER_WORD - 1)) begin
                    pack_cnt  <= 2'd0;
                    word_wr_o <= 1'b1;  // word complete next cycle
                end else begin
                    pack_cnt <= pack_cnt + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: byte_unpacker.sv
`default_nettype none

module byte_unpacker (
    input  wire                                adc_sampleclk,
    input  wire                                reset,
    input  wire                                clear_i,
    input  wire adc_capture_pkg::word_t        word_i,
    input  wire                                low_res_i,
    input  wire                                low_res_lsb_i,
    input  wire                                fifo_read_en_i,
    output logic                               word_rd_o,
    output logic [adc_capture_pkg::BYTE_W-1:0] read_data_o
);

    logic [3:0] byte_cnt;   // 0..8 full res, 0..2 low res
    logic [3:0] nibble_r;   // tail of the first word of a pair
    logic       last_byte;
    logic       wrap;
    logic [5:0] lr_base;

    assign last_byte = low_res_i ? (byte_cnt == 4'd2)
                                 : ((byte_cnt == 4'd3) || (byte_cnt == 4'd8));
    assign wrap      = low_res_i ? (byte_cnt == 4'd2) : (byte_cnt == 4'd8);

    // pop on the byte that finishes the head word
    assign word_rd_o = fifo_read_en_i & last_byte;

    always_ff @(posedge adc_sampleclk) begin
        if (reset || clear_i)
            byte_cnt <= 4'd0;
        else if (fifo_read_en_i) begin
            if (wrap)
                byte_cnt <= 4'd0;
            else
                byte_cnt <= byte_cnt + 1'b1;
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (fifo_read_en_i && !low_res_i && (byte_cnt == 4'd3))
            nibble_r <= word_i[3:0];
    end

    // low res: slot 0 is the oldest sample at the top of the word
    always_comb begin
        case (byte_cnt)
            4'd0:    lr_base = 6'd24;
            4'd1:    lr_base = 6'd12;
            default: lr_base = 6'd0;
        endcase
        if (!low_res_lsb_i)
            lr_base = lr_base + 6'd4;   // upper 8 of 12
    end

    always_comb begin
        if (low_res_i) begin
            read_data_o = word_i[lr_base +: adc_capture_pkg::BYTE_W];
        end else begin
            // 9 bytes carry two words, msb first
            case (byte_cnt)
                4'd0:    read_data_o = word_i[35:28];
                4'd1:    read_data_o = word_i[27:20];
                4'd2:    read_data_o = word_i[19:12];
                4'd3:    read_data_o = word_i[11:4];
                4'd4:    read_data_o = {nibble_r, word_i[35:32]};
                4'd5:    read_data_o = word_i[31:24];
                4'd6:    read_data_o = word_i[23:16];
                4'd7:    read_data_o = word_i[15:8];
                4'd8:    read_data_o = word_i[7:0];
                default: read_data_o = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: adc_capture_top.sv
`default_nettype none

module adc_capture_top #(
    parameter int SAMPLE_DEPTH = 64,    // must exceed presample_i
    parameter int WORD_DEPTH   = 256
) (
    input  wire                                adc_sampleclk,
    input  wire                                reset,
    input  wire adc_capture_pkg::sample_t      adc_datain_i,
    input  wire                                arm_i,
    input  wire                                adc_capture_go_i,
    input  wire [adc_capture_pkg::COUNT_W-1:0] presample_i,
    input  wire [adc_capture_pkg::COUNT_W-1:0] max_samples_i,
    input  wire [adc_capture_pkg::DS_W-1:0]    downsample_i,
    input  wire                                low_res_i,
    input  wire                                low_res_lsb_i,
    input  wire                                fifo_read_en_i,
    output logic                               adc_capture_stop_o,
    output logic                               fifo_empty_o,
    output logic [adc_capture_pkg::BYTE_W-1:0] read_data_o,
    output logic                               error_flag_o
);

    logic                            sample_wr;
    logic                            drain_rd;
    logic                            arm_clear;
    adc_capture_pkg::capture_state_t state;
    logic                            sample_rd;
    adc_capture_pkg::sample_t        sample_dout;
    logic                            sample_empty;
    logic                            sample_ovf;
    logic                            sample_unf;
    adc_capture_pkg::word_t          packed_word;
    logic                            word_wr;
    logic                            word_rd;
    logic                            word_buf_rd;
    adc_capture_pkg::word_t          word_dout;
    logic                            word_full;
    logic                            word_ovf;
    logic                            word_unf;
    logic                            packer_idle;

    capture_ctrl u_ctrl (
        .adc_sampleclk    (adc_sampleclk),
        .reset            (reset),
        .arm_i            (arm_i),
        .adc_capture_go_i (adc_capture_go_i),
        .presample_i      (presample_i),
        .max_samples_i    (max_samples_i),
        .downsample_i     (downsample_i),
        .sample_empty_i   (sample_empty),
        .packer_idle_i    (packer_idle),
        .sample_wr_o      (sample_wr),
        .drain_rd_o       (drain_rd),
        .arm_clear_o      (arm_clear),
        .state_o          (state),
        .capture_stop_o   (adc_capture_stop_o)
    );

    sample_fifo #(
        .DEPTH     (SAMPLE_DEPTH),
        .payload_t (adc_capture_pkg::sample_t)
    ) sample_buf (
        .adc_sampleclk (adc_sampleclk),
        .reset         (reset),
        .clear_i       (arm_clear),
        .din_i         (adc_datain_i),
        .wr_i          (sample_wr),
        .rd_i          (drain_rd | sample_rd),   // never both at once
        .dout_o        (sample_dout),
        .full_o        (),                       // overflow pulse covers it
        .empty_o       (sample_empty),
        .overflow_o    (sample_ovf),
        .underflow_o   (sample_unf)
    );

    sample_packer u_packer (
        .adc_sampleclk  (adc_sampleclk),
        .reset          (reset),
        .clear_i        (arm_clear),
        .state_i        (state),
        .sample_i       (sample_dout),
        .sample_empty_i (sample_empty),
        .word_full_i    (word_full),
        .sample_rd_o    (sample_rd),
        .word_o         (packed_word),
        .word_wr_o      (word_wr),
        .idle_o         (packer_idle)
    );

    // a byte requested with nothing buffered is a read on empty
    assign word_buf_rd = word_rd | (fifo_read_en_i & fifo_empty_o);

    sample_fifo #(
        .DEPTH     (WORD_DEPTH),
        .payload_t (adc_capture_pkg::word_t)
    ) word_buf (
        .adc_sampleclk (adc_sampleclk),
        .reset         (reset),
        .clear_i       (arm_clear),
        .din_i         (packed_word),
        .wr_i          (word_wr),
        .rd_i          (word_buf_rd),
        .dout_o        (word_dout),
        .full_o        (word_full),
        .empty_o       (fifo_empty_o),
        .overflow_o    (word_ovf),
        .underflow_o   (word_unf)
    );

    byte_unpacker u_unpacker (
        .adc_sampleclk  (adc_sampleclk),
        .reset          (reset),
        .clear_i        (arm_clear),
        .word_i         (word_dout),
        .low_res_i      (low_res_i),
        .low_res_lsb_i  (low_res_lsb_i),
        .fifo_read_en_i (fifo_read_en_i),
        .word_rd_o      (word_rd),
        .read_data_o    (read_data_o)
    );

    // sticky until the next arm
    always_ff @(posedge adc_sampleclk) begin
        if (reset || arm_clear)
            error_flag_o <= 1'b0;
        else if (sample_ovf || sample_unf || word_ovf || word_unf)
            error_flag_o <= 1'b1;
    end

endmodule

`default_nettype wire

// File: adc_capture_checker.sv
`default_nettype none

module adc_capture_checker (
    input wire adc_sampleclk,
    input wire reset,
    input wire arm_i,
    input wire fifo_read_en_i,
    input wire fifo_empty_o,
    input wire adc_capture_stop_o,
    input wire error_flag_o
);

    int fail_cnt = 0;   // read by the testbench at the end

    // stop drops three edges after arm is seen high
    stop_until_arm: assert property (@(posedge adc_sampleclk) disable iff (reset)
        $fell(adc_capture_stop_o) |-> $past(arm_i, 3) && !$past(arm_i, 4))
        else begin
            fail_cnt++;
            $error("capture stop fell without an arm edge");
        end

    // underflow pulse, then the flag one cycle later
    error_needs_bad_read: assert property (@(posedge adc_sampleclk) disable iff (reset)
        $rose(error_flag_o) |-> $past(fifo_read_en_i && fifo_empty_o, 2))
        else begin
            fail_cnt++;
            $error("error flag set without a read on an empty buffer");
        end

    empty_after_arm: assert property (@(posedge adc_sampleclk) disable iff (reset)
        $rose(arm_i) |-> ##[1:4] fifo_empty_o)
        else begin
            fail_cnt++;
            $error("word buffer not emptied after arm");
        end

endmodule

bind adc_capture_top adc_capture_checker u_checker (
    .adc_sampleclk      (adc_sampleclk),
    .reset              (reset),
    .arm_i              (arm_i),
    .fifo_read_en_i     (fifo_read_en_i),
    .fifo_empty_o       (fifo_empty_o),
    .adc_capture_stop_o (adc_capture_stop_o),
    .error_flag_o       (error_flag_o)
);

`default_nettype wire

// File: tb_adc_capture.sv
`default_nettype none

module tb_adc_capture;

    localparam int NUM_TESTS = 10;
    localparam int FIELDS    = 8;   // values per pattern line

    logic                                adc_sampleclk;
    logic                                reset;
    adc_capture_pkg::sample_t            adc_datain_i;
    logic                                arm_i;
    logic                                adc_capture_go_i;
    logic [adc_capture_pkg::COUNT_W-1:0] presample_i;
    logic [adc_capture_pkg::COUNT_W-1:0] max_samples_i;
    logic [adc_capture_pkg::DS_W-1:0]    downsample_i;
    logic                                low_res_i;
    logic                                low_res_lsb_i;
    logic                                fifo_read_en_i;
    logic                                adc_capture_stop_o;
    logic                                fifo_empty_o;
    logic [adc_capture_pkg::BYTE_W-1:0]  read_data_o;
    logic                                error_flag_o;

    logic [15:0] patterns [NUM_TESTS*FIELDS];
    logic [7:0]  bytes_q [$];
    int          samples [$];
    int          err_count;
    int          fail_tests;
    int unsigned seed;
    longint      cycle_cnt = 0;
    longint      cycle_limit;

    adc_capture_top DUT (
        .adc_sampleclk      (adc_sampleclk),
        .reset              (reset),
        .adc_datain_i       (adc_datain_i),
        .arm_i              (arm_i),
        .adc_capture_go_i   (adc_capture_go_i),
        .presample_i        (presample_i),
        .max_samples_i      (max_samples_i),
        .downsample_i       (downsample_i),
        .low_res_i          (low_res_i),
        .low_res_lsb_i      (low_res_lsb_i),
        .fifo_read_en_i     (fifo_read_en_i),
        .adc_capture_stop_o (adc_capture_stop_o),
        .fifo_empty_o       (fifo_empty_o),
        .read_data_o        (read_data_o),
        .error_flag_o       (error_flag_o)
    );

    initial begin
        adc_sampleclk = 1'b0;
        forever #2 adc_sampleclk = ~adc_sampleclk;
    end

    // ramp input, one step per clock
    initial begin
        adc_datain_i = '0;
        forever begin
            @(posedge adc_sampleclk);
            #1 adc_datain_i = adc_datain_i + 1'b1;
        end
    end

    always @(posedge adc_sampleclk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("run timed out after %0d cycles", cycle_cnt);
            $display("Simulation FAILED");
            $finish;
        end
    end

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            err_count++;
            $display("mismatch at %0t: %s, got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic next_cycle;
        @(posedge adc_sampleclk);
        #1;
    endtask

    // low res byte of a ramp value, taken mod 4096
    function automatic logic [7:0] ramp_byte(input int value, input bit lsb);
        logic [11:0] s;
        s = value[11:0];
        ramp_byte = lsb ? s[7:0] : s[11:4];
    endfunction

    // arm, trigger dly cycles after the arm edge, wait until drained
    task automatic capture_samples(input int dly, output int trig);
        next_cycle();
        arm_i = 1'b1;
        next_cycle();
        arm_i = 1'b0;
        repeat (dly - 1) next_cycle();
        adc_capture_go_i = 1'b1;
        #1 trig = adc_datain_i;     // value sampled at the trigger edge
        while (adc_capture_stop_o)
            next_cycle();           // stop of the last run is still up
        while (!(adc_capture_stop_o && DUT.state == adc_capture_pkg::idle))
            next_cycle();
        adc_capture_go_i = 1'b0;
    endtask

    task automatic run_test(input int t);
        int          p, max_s, ds, lr, lsb, dly, exp_cnt, extra;
        int          step, errs_before, below, lo, found, trig, c, j, k, n;
        bit          ok;
        logic [71:0] group;
        p       = patterns[t*FIELDS];
        max_s   = patterns[t*FIELDS + 1];
        ds      = patterns[t*FIELDS + 2];
        lr      = patterns[t*FIELDS + 3];
        lsb     = patterns[t*FIELDS + 4];
        dly     = patterns[t*FIELDS + 5];
        exp_cnt = patterns[t*FIELDS + 6];
        extra   = patterns[t*FIELDS + 7];
        step        = ds + 1;
        errs_before = err_count;
        presample_i   = p;
        max_samples_i = max_s;
        downsample_i  = ds;
        low_res_i     = lr[0];
        low_res_lsb_i = lsb[0];

        // stale run, left in the buffers with one byte taken
        capture_samples(dly, trig);
        fifo_read_en_i = 1'b1;
        next_cycle();
        fifo_read_en_i = 1'b0;

        // the rearm must drop everything from the stale run
        capture_samples(dly, trig);
        check_value("error flag before readout", error_flag_o, 0);

        bytes_q.delete();
        while (!fifo_empty_o) begin
            repeat ($urandom % 3) next_cycle();
            fifo_read_en_i = 1'b1;
            @(negedge adc_sampleclk);
            bytes_q.push_back(read_data_o);
            next_cycle();
            fifo_read_en_i = 1'b0;
        end
        if (extra != 0) begin
            fifo_read_en_i = 1'b1;  // one byte too many
            next_cycle();
            fifo_read_en_i = 1'b0;
            repeat (2) next_cycle();
            check_value("error flag after read on empty buffer", error_flag_o, 1);
        end

        if (lr != 0) begin
            check_value("byte count", bytes_q.size(), exp_cnt);
            lo    = (p > 0) ? trig - p * step : trig;
            found = -1;
            for (c = lo; c <= lo + step; c++) begin
                ok = 1'b1;
                for (k = 0; k < bytes_q.size(); k++)
                    if (ramp_byte(c + k * step, lsb[0]) != bytes_q[k])
                        ok = 1'b0;
                if (ok && found < 0)
                    found = c;
            end
            if (found < 0)
                found = lo;
            for (k = 0; k < bytes_q.size(); k++)
                check_value("low res byte", bytes_q[k], ramp_byte(found + k * step, lsb[0]));
        end else begin
            samples.delete();
            for (k = 0; k + 8 < bytes_q.size(); k += 9) begin
                for (j = 0; j < 9; j++)
                    group = {group[63:0], bytes_q[k + j]};
                for (j = 0; j < 6; j++)
                    samples.push_back(group[71 - 12 * j -: 12]);   // msb first
            end
            n = samples.size();
            check_value("bytes in whole groups of 9", bytes_q.size() % 9, 0);
            check_value("sample count", n, exp_cnt);
            for (k = 1; k < n; k++)
                check_value("sample step", (samples[k] - samples[k - 1]) & 12'hfff, step);
            if (p == 0 && n > 0)
                check_value("first sample within one step of trigger",
                            ((samples[0] - trig) & 12'hfff) <= step, 1);
            if (p > 0 && dly >= (p + 2) * step) begin
                below = 0;
                for (k = 0; k < n; k++)
                    if (((samples[k] - trig) & 12'hfff) >= 2048)
                        below++;    // behind the trigger on the ramp
                check_value("samples before trigger", below, p);
            end
        end

        if (err_count != errs_before)
            fail_tests++;
        $display("test %0d %s: presample %0d max %0d downsample %0d low_res %0d lsb %0d",
                 t, (err_count == errs_before) ? "ok" : "failed", p, max_s, ds, lr, lsb);
    endtask

    initial begin
        int t;
        seed = 32'h31493de5;
        void'($urandom(seed));
        reset            = 1'b1;
        arm_i            = 1'b0;
        adc_capture_go_i = 1'b0;
        presample_i      = '0;
        max_samples_i    = '0;
        downsample_i     = '0;
        low_res_i        = 1'b0;
        low_res_lsb_i    = 1'b0;
        fifo_read_en_i   = 1'b0;
        err_count        = 0;
        fail_tests       = 0;
        $readmemh("adc_capture_patterns.txt", patterns);
        cycle_limit = 0;
        for (t = 0; t < NUM_TESTS; t++)
            cycle_limit += patterns[t*FIELDS + 1] * (patterns[t*FIELDS + 2] + 1) +
                           patterns[t*FIELDS + 5] + 200;
        cycle_limit = 64 * cycle_limit;
        repeat (8) @(posedge adc_sampleclk);
        #1 reset = 1'b0;
        for (t = 0; t < NUM_TESTS; t++)
            run_test(t);
        $display("%0d tests, %0d failed, %0d mismatches, %0d assertion failures",
                 NUM_TESTS, fail_tests, err_count, DUT.u_checker.fail_cnt);
        if (err_count == 0 && DUT.u_checker.fail_cnt == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: adc_capture_patterns.txt
// hex columns: presample max_samples downsample low_res low_res_lsb
//              trigger_delay expected_count extra_read
0000 003c 0000 0000 0000 000a 003c 0000
0008 0060 0000 0000 0000 0014 0060 0001
000a 0078 0002 0000 0000 002d 0078 0000
0000 0030 0004 0000 0000 0007 0030 0000
0005 003f 0001 0001 0000 0014 003f 0000
0000 002d 0003 0001 0001 0006 002d 0001
0014 0048 0000 0000 0000 000a 0048 0000
0028 012c 0000 0000 0000 003c 012c 0000
000c 005a 0000 0001 0001 0019 005a 0000
0003 001e 0005 0000 0000 0028 001e 0000

// File: flist.f
adc_capture_pkg.sv
sample_fifo.sv
capture_ctrl.sv
sample_packer.sv
byte_unpacker.sv
adc_capture_top.sv
adc_capture_checker.sv
tb_adc_capture.sv
